//--- hdl/mm_geom_pkg.sv
package mm_geom_pkg;

  // element and array geometry
  localparam int DWIDTH = 16;
  localparam int MAT_N = 4;

  // row memory geometry
  localparam int AWIDTH = 7;
  localparam int MEM_SIZE = 128;

  typedef logic [DWIDTH-1:0] elem_t;
  typedef logic [AWIDTH-1:0] addr_t;

  // one memory row
  // raw is the flat host word
  // elem splits it into per-lane elements, elem[0] in the low bits
  typedef union packed {
    logic [MAT_N*DWIDTH-1:0] raw;
    elem_t [MAT_N-1:0]       elem;
  } mat_row_u;

endpackage

//--- hdl/mm_ctrl_pkg.sv
package mm_ctrl_pkg;

  import mm_geom_pkg::*;

  // full product width, wide enough for any single 16x16 product
  typedef logic [2*DWIDTH-1:0] acc_t;

  // value of a saturated result element
  localparam elem_t SAT_MAX = '1;

  // operand words read per run, one per k
  localparam int FEED_CYCLES = MAT_N;

  // registered read in row_ram
  localparam int READ_LATENCY = 1;

  // address register plus memory read
  localparam int HOST_RD_LATENCY = 2;

endpackage

//--- hdl/operand_stream_if.sv
`timescale 1ns/1ps

interface operand_stream_if;
  import mm_geom_pkg::*;

  // lane i trails lane 0 by i cycles
  mat_row_u         a_lanes;
  mat_row_u         b_lanes;
  logic [MAT_N-1:0] lane_valid;
  // single pulse ahead of the first operand
  logic             clear;

  modport feeder (
    output a_lanes,
    output b_lanes,
    output lane_valid,
    output clear
  );

  modport array (
    input a_lanes,
    input b_lanes,
    input lane_valid,
    input clear
  );

endinterface

//--- hdl/result_row_if.sv
`timescale 1ns/1ps

interface result_row_if;
  import mm_geom_pkg::*;

  // row i holds saturated C[i][0..3]
  mat_row_u [MAT_N-1:0] c_rows;
  // c_rows is stable from this pulse until the next clear
  logic                 results_ready;

  modport array (
    output c_rows,
    output results_ready
  );

  modport drain (
    input c_rows,
    input results_ready
  );

endinterface

//--- hdl/row_ram.sv
`timescale 1ns/1ps

module row_ram (
  input  logic                  clk,
  input  mm_geom_pkg::addr_t    addr,
  input  mm_geom_pkg::mat_row_u wdata,
  input  logic                  we,
  output mm_geom_pkg::mat_row_u rdata
);
  import mm_geom_pkg::*;

  mat_row_u mem [MEM_SIZE];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // old contents on a same-cycle write
    rdata <= mem[addr];
  end

endmodule

//--- hdl/operand_feeder.sv
`timescale 1ns/1ps

module operand_feeder (
  input  logic               clk,
  input  logic               reset,
  input  logic               start_mat_mul,
  input  mm_geom_pkg::addr_t host_addr,
  input  logic [63:0]        host_wdata,
  input  logic               host_we_a,
  input  logic               host_we_b,
  operand_stream_if.feeder   stream
);
  import mm_geom_pkg::*;
  import mm_ctrl_pkg::*;

  addr_t                   rd_cnt;
  addr_t                   ram_addr;
  logic                    feed_active;
  logic                    start_q;
  logic [READ_LATENCY-1:0] rd_pipe;
  logic                    rd_valid;
  mat_row_u                wr_row;
  mat_row_u                a_rdata;
  mat_row_u                b_rdata;
  elem_t                   a_lane [MAT_N];
  elem_t                   b_lane [MAT_N];
  logic                    v_lane [MAT_N];

  assign wr_row.raw = host_wdata;

  // host owns the memories while idle, the read counter during a run
  assign ram_addr = start_mat_mul ? rd_cnt : host_addr;
  assign feed_active = start_mat_mul && (rd_cnt < FEED_CYCLES);

  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      rd_cnt <= '0;
    end else if (feed_active) begin
      rd_cnt <= rd_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
      rd_pipe <= '0;
    end else begin
      start_q <= start_mat_mul;
      rd_pipe <= READ_LATENCY'({rd_pipe, feed_active});
    end
  end

  // valid lines up with the registered memory output
  assign rd_valid = rd_pipe[READ_LATENCY-1];
  assign stream.clear = start_mat_mul && !start_q;

  row_ram u_ram_a (
    .clk   (clk),
    .addr  (ram_addr),
    .wdata (wr_row),
    .we    (host_we_a && !start_mat_mul),
    .rdata (a_rdata)
  );

  row_ram u_ram_b (
    .clk   (clk),
    .addr  (ram_addr),
    .wdata (wr_row),
    .we    (host_we_b && !start_mat_mul),
    .rdata (b_rdata)
  );

  for (genvar i = 0; i < MAT_N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign a_lane[i] = a_rdata.elem[i];
      assign b_lane[i] = b_rdata.elem[i];
      assign v_lane[i] = rd_valid;
    end else begin : g_skew
      // i-stage delay line for this lane
      elem_t a_dly [i];
      elem_t b_dly [i];
      logic  v_dly [i];

      always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
          for (int s = 0; s < i; s++) begin
            a_dly[s] <= '0;
            b_dly[s] <= '0;
            v_dly[s] <= 1'b0;
          end
        end else begin
          a_dly[0] <= a_rdata.elem[i];
          b_dly[0] <= b_rdata.elem[i];
          v_dly[0] <= rd_valid;
          for (int s = 1; s < i; s++) begin
            a_dly[s] <= a_dly[s-1];
            b_dly[s] <= b_dly[s-1];
            v_dly[s] <= v_dly[s-1];
          end
        end
      end

      assign a_lane[i] = a_dly[i-1];
      assign b_lane[i] = b_dly[i-1];
      assign v_lane[i] = v_dly[i-1];
    end
  end

  always_comb begin
    for (int k = 0; k < MAT_N; k++) begin
      stream.a_lanes.elem[k] = a_lane[k];
      stream.b_lanes.elem[k] = b_lane[k];
      stream.lane_valid[k]   = v_lane[k];
    end
  end

endmodule

//--- hdl/processing_element.sv
`timescale 1ns/1ps

module processing_element (
  input  logic               clk,
  input  logic               reset,
  input  logic               clear,
  input  mm_geom_pkg::elem_t in_a,
  input  mm_geom_pkg::elem_t in_b,
  input  logic               in_valid,
  output mm_geom_pkg::elem_t out_a,
  output mm_geom_pkg::elem_t out_b,
  output logic               out_valid,
  output mm_geom_pkg::elem_t out_c
);
  import mm_geom_pkg::*;
  import mm_ctrl_pkg::*;

  acc_t                  acc;
  acc_t                  prod;
  logic [$bits(acc_t):0] sum;

  assign prod = acc_t'(in_a) * acc_t'(in_b);
  // carry bit catches a wrap of the 32-bit sum
  assign sum = {1'b0, acc} + prod;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else if (in_valid) begin
      acc <= sum[$bits(acc_t)] ? '1 : sum[$bits(acc_t)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // operands hop one cell per cycle
  always_ff @(posedge clk) begin
    out_a <= in_a;
    out_b <= in_b;
  end

  // clamp to 16 bits
  assign out_c = (|acc[$bits(acc_t)-1:DWIDTH]) ? SAT_MAX : acc[DWIDTH-1:0];

endmodule

//--- hdl/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
  input  logic            clk,
  input  logic            reset,
  operand_stream_if.array stream,
  result_row_if.array     results
);
  import mm_geom_pkg::*;

  // a moves right, b moves down, valid travels with a
  elem_t a_w [MAT_N][MAT_N+1];
  elem_t b_w [MAT_N+1][MAT_N];
  logic  v_w [MAT_N][MAT_N+1];
  elem_t c_w [MAT_N][MAT_N];
  logic  last_valid;
  logic  last_valid_q;

  // row lanes enter on the left, column lanes at the top
  for (genvar e = 0; e < MAT_N; e++) begin : g_edge
    assign a_w[e][0] = stream.a_lanes.elem[e];
    assign v_w[e][0] = stream.lane_valid[e];
    assign b_w[0][e] = stream.b_lanes.elem[e];
  end

  for (genvar i = 0; i < MAT_N; i++) begin : g_row
    for (genvar j = 0; j < MAT_N; j++) begin : g_col
      processing_element u_pe (
        .clk       (clk),
        .reset     (reset),
        .clear     (stream.clear),
        .in_a      (a_w[i][j]),
        .in_b      (b_w[i][j]),
        .in_valid  (v_w[i][j]),
        .out_a     (a_w[i][j+1]),
        .out_b     (b_w[i+1][j]),
        .out_valid (v_w[i][j+1]),
        .out_c     (c_w[i][j])
      );
    end
  end

  always_comb begin
    for (int r = 0; r < MAT_N; r++) begin
      for (int c = 0; c < MAT_N; c++) begin
        results.c_rows[r].elem[c] = c_w[r][c];
      end
    end
  end

  // valid leaving the bottom right cell
  assign last_valid = v_w[MAT_N-1][MAT_N];

  // the last operand has passed every cell once this valid falls
  always_ff @(posedge clk) begin
    if (reset) begin
      last_valid_q          <= 1'b0;
      results.results_ready <= 1'b0;
    end else begin
      last_valid_q          <= last_valid;
      results.results_ready <= last_valid_q && !last_valid;
    end
  end

endmodule

//--- hdl/result_drain.sv
`timescale 1ns/1ps

module result_drain (
  input  logic               clk,
  input  logic               reset,
  input  logic               start_mat_mul,
  result_row_if.drain        results,
  input  mm_geom_pkg::addr_t host_addr,
  input  logic               host_rd,
  output logic [63:0]        host_rdata,
  output logic               host_rvalid,
  output logic               done_mat_mul
);
  import mm_geom_pkg::*;
  import mm_ctrl_pkg::*;

  mat_row_u [MAT_N-1:0]       c_buf;
  mat_row_u                   c_rdata;
  addr_t                      wr_idx;
  addr_t                      rd_addr_q;
  addr_t                      ram_addr;
  logic                       writing;
  logic                       last_row;
  logic [HOST_RD_LATENCY-1:0] rv_pipe;

  assign last_row = writing && (wr_idx == MAT_N-1);

  always_ff @(posedge clk) begin
    if (results.results_ready) begin
      c_buf <= results.c_rows;
    end
  end

  // one C row per cycle, row i to address i
  always_ff @(posedge clk) begin
    if (reset) begin
      writing <= 1'b0;
      wr_idx  <= '0;
    end else if (results.results_ready) begin
      writing <= 1'b1;
      wr_idx  <= '0;
    end else if (writing) begin
      wr_idx <= wr_idx + 1'b1;
      if (last_row) begin
        writing <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      done_mat_mul <= 1'b0;
    end else if (last_row) begin
      done_mat_mul <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (host_rd) begin
      rd_addr_q <= host_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rv_pipe <= '0;
    end else begin
      rv_pipe <= HOST_RD_LATENCY'({rv_pipe, host_rd && !start_mat_mul});
    end
  end

  assign ram_addr = writing ? wr_idx : rd_addr_q;

  row_ram u_ram_c (
    .clk   (clk),
    .addr  (ram_addr),
    .wdata (c_buf[wr_idx]),
    .we    (writing),
    .rdata (c_rdata)
  );

  assign host_rdata  = c_rdata.raw;
  assign host_rvalid = rv_pipe[HOST_RD_LATENCY-1];

endmodule

//--- hdl/matmul_top.sv
`timescale 1ns/1ps

module matmul_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               start_mat_mul,
  output logic               done_mat_mul,
  input  mm_geom_pkg::addr_t host_addr,
  input  logic [63:0]        host_wdata,
  input  logic               host_we_a,
  input  logic               host_we_b,
  input  logic               host_rd,
  output logic [63:0]        host_rdata,
  output logic               host_rvalid
);

  operand_stream_if u_stream ();
  result_row_if     u_results ();

  // A and B memories, skewed operand lanes
  operand_feeder u_feeder (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_we_a     (host_we_a),
    .host_we_b     (host_we_b),
    .stream        (u_stream)
  );

  systolic_array u_array (
    .clk     (clk),
    .reset   (reset),
    .stream  (u_stream),
    .results (u_results)
  );

  // C memory, done flag and host readback
  result_drain u_drain (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .results       (u_results),
    .host_addr     (host_addr),
    .host_rd       (host_rd),
    .host_rdata    (host_rdata),
    .host_rvalid   (host_rvalid),
    .done_mat_mul  (done_mat_mul)
  );

endmodule

//--- sim/mm_cases.svh
// fixed cases, one matrix row per line, elements listed from column 0 up
localparam int NUM_FIXED = 3;

logic [63:0] tab_a [NUM_FIXED][MAT_N];
logic [63:0] tab_b [NUM_FIXED][MAT_N];
logic [63:0] tab_c [NUM_FIXED][MAT_N];

// element j lands in bits 16j+15:16j
function automatic logic [63:0] pack_row(input int e0, input int e1, input int e2, input int e3);
  return {e3[15:0], e2[15:0], e1[15:0], e0[15:0]};
endfunction

task automatic fill_case_table();
  // identity times B gives B back
  tab_a[0][0] = pack_row(1, 0, 0, 0);
  tab_a[0][1] = pack_row(0, 1, 0, 0);
  tab_a[0][2] = pack_row(0, 0, 1, 0);
  tab_a[0][3] = pack_row(0, 0, 0, 1);
  tab_b[0][0] = pack_row('h0011, 'h0022, 'h0033, 'h0044);
  tab_b[0][1] = pack_row('h1000, 'h2000, 'h3000, 'h4000);
  tab_b[0][2] = pack_row('habcd, 'h0001, 'hffff, 'h1234);
  tab_b[0][3] = pack_row('h0000, 'h00ff, 'h7fff, 'h8000);
  tab_c[0][0] = pack_row('h0011, 'h0022, 'h0033, 'h0044);
  tab_c[0][1] = pack_row('h1000, 'h2000, 'h3000, 'h4000);
  tab_c[0][2] = pack_row('habcd, 'h0001, 'hffff, 'h1234);
  tab_c[0][3] = pack_row('h0000, 'h00ff, 'h7fff, 'h8000);
  // small values, exact products
  tab_a[1][0] = pack_row(1, 2, 3, 4);
  tab_a[1][1] = pack_row(5, 6, 7, 8);
  tab_a[1][2] = pack_row(9, 10, 11, 12);
  tab_a[1][3] = pack_row(13, 14, 15, 16);
  tab_b[1][0] = pack_row(2, 0, 1, 3);
  tab_b[1][1] = pack_row(1, 4, 0, 2);
  tab_b[1][2] = pack_row(0, 1, 5, 1);
  tab_b[1][3] = pack_row(3, 2, 2, 0);
  tab_c[1][0] = pack_row(16, 19, 24, 10);
  tab_c[1][1] = pack_row(40, 47, 56, 34);
  tab_c[1][2] = pack_row(64, 75, 88, 58);
  tab_c[1][3] = pack_row(88, 103, 120, 82);
  // saturated elements mixed with exact ones
  tab_a[2][0] = pack_row('h0100, 0, 0, 0);
  tab_a[2][1] = pack_row(1, 1, 0, 0);
  tab_a[2][2] = pack_row('hffff, 0, 0, 0);
  tab_a[2][3] = pack_row(0, 0, 0, 2);
  tab_b[2][0] = pack_row('h0100, 'h00ff, 'h0001, 0);
  tab_b[2][1] = pack_row('h8000, 'h0001, 0, 'h0002);
  tab_b[2][2] = pack_row(0, 0, 0, 0);
  tab_b[2][3] = pack_row('h8000, 'h7fff, 'h0003, 'h1000);
  tab_c[2][0] = pack_row('hffff, 'hff00, 'h0100, 0);
  tab_c[2][1] = pack_row('h8100, 'h0100, 'h0001, 'h0002);
  tab_c[2][2] = pack_row('hffff, 'hffff, 'hffff, 0);
  tab_c[2][3] = pack_row('hffff, 'hfffe, 'h0006, 'h2000);
endtask

//--- sim/matmul_tb.sv
`timescale 1ns/1ps

module matmul_tb;
  import mm_geom_pkg::*;
  import mm_ctrl_pkg::*;

  localparam int NUM_RANDOM = 4;
  // loads, one run and four readbacks plus margin
  localparam int CASE_CYCLES = 100;
  localparam logic [31:0] SEED = 32'hc2d2_524d;

  logic        clk = 1'b0;
  logic        reset;
  logic        start_mat_mul;
  logic        done_mat_mul;
  addr_t       host_addr;
  logic [63:0] host_wdata;
  logic        host_we_a;
  logic        host_we_b;
  logic        host_rd;
  logic [63:0] host_rdata;
  logic        host_rvalid;

  logic [63:0] cur_a [MAT_N];
  logic [63:0] cur_b [MAT_N];
  logic [63:0] cur_c [MAT_N];
  int          cycle_count = 0;
  int          error_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  `include "mm_cases.svh"

  localparam int NUM_CASES = NUM_FIXED + NUM_RANDOM;
  localparam int CYCLE_LIMIT = 16 + NUM_CASES * CASE_CYCLES;

  matmul_top u_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp, got);
    $display("ERROR t=%0t %s: expected %h, got %h", $time, name, exp, got);
    error_count++;
  endtask

  // C[i][j] is the sum over k of A[i][k] * B[k][j] clamped to 16 bits
  function automatic logic [63:0] expected_row(input int i);
    logic [63:0] res;
    logic [63:0] sum;
    res = '0;
    for (int j = 0; j < MAT_N; j++) begin
      sum = '0;
      for (int k = 0; k < MAT_N; k++) begin
        sum += 64'(cur_a[i][16*k +: 16]) * 64'(cur_b[k][16*j +: 16]);
      end
      res[16*j +: 16] = (sum > 64'd65535) ? 16'hffff : sum[15:0];
    end
    return res;
  endfunction

  task automatic make_random_case(input int idx);
    int limit;
    // narrow values on even cases and full range on odd ones
    limit = (idx % 2 == 0) ? 255 : 65535;
    for (int r = 0; r < MAT_N; r++) begin
      for (int e = 0; e < MAT_N; e++) begin
        cur_a[r][16*e +: 16] = 16'($urandom % (limit + 1));
        cur_b[r][16*e +: 16] = 16'($urandom % (limit + 1));
      end
    end
    for (int r = 0; r < MAT_N; r++) begin
      cur_c[r] = expected_row(r);
    end
  endtask

  // A one column per word and B one row per word
  task automatic load_operands();
    logic [63:0] col;
    for (int k = 0; k < 2 * MAT_N; k++) begin
      for (int i = 0; i < MAT_N; i++) begin
        col[16*i +: 16] = cur_a[i][16*(k % MAT_N) +: 16];
      end
      @(negedge clk);
      host_addr  = addr_t'(k % MAT_N);
      host_wdata = (k < MAT_N) ? col : cur_b[k % MAT_N];
      host_we_a  = (k < MAT_N);
      host_we_b  = (k >= MAT_N);
    end
    @(negedge clk);
    host_we_b = 1'b0;
  endtask

  task automatic run_product();
    @(negedge clk);
    if (done_mat_mul !== 1'b0) report_mismatch("done_mat_mul", 64'd0, 64'(done_mat_mul));
    start_mat_mul = 1'b1;
    @(negedge clk);
    while (done_mat_mul !== 1'b1) begin
      @(negedge clk);
    end
    // done holds as long as start does
    repeat (2) @(negedge clk);
    if (done_mat_mul !== 1'b1) report_mismatch("done_mat_mul", 64'd1, 64'(done_mat_mul));
    start_mat_mul = 1'b0;
    @(negedge clk);
    if (done_mat_mul !== 1'b0) report_mismatch("done_mat_mul", 64'd0, 64'(done_mat_mul));
  endtask

  task automatic read_c_row(input int r);
    @(negedge clk);
    host_addr = addr_t'(r);
    host_rd   = 1'b1;
    @(negedge clk);
    host_rd = 1'b0;
    for (int n = 1; n < HOST_RD_LATENCY; n++) begin
      if (host_rvalid !== 1'b0) report_mismatch("host_rvalid", 64'd0, 64'(host_rvalid));
      @(negedge clk);
    end
    if (host_rvalid !== 1'b1) report_mismatch("host_rvalid", 64'd1, 64'(host_rvalid));
    if (host_rdata !== cur_c[r]) report_mismatch($sformatf("host_rdata row %0d", r),
                                                 cur_c[r], host_rdata);
  endtask

  initial begin
    int errors_before;
    reset         = 1'b1;
    start_mat_mul = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    host_we_a     = 1'b0;
    host_we_b     = 1'b0;
    host_rd       = 1'b0;
    void'($urandom(SEED));
    fill_case_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (done_mat_mul !== 1'b0) report_mismatch("done_mat_mul", 64'd0, 64'(done_mat_mul));
    if (host_rvalid !== 1'b0) report_mismatch("host_rvalid", 64'd0, 64'(host_rvalid));
    for (int t = 0; t < NUM_CASES; t++) begin
      errors_before = error_count;
      if (t < NUM_FIXED) begin
        for (int r = 0; r < MAT_N; r++) begin
          cur_a[r] = tab_a[t][r];
          cur_b[r] = tab_b[t][r];
          cur_c[r] = tab_c[t][r];
        end
      end else begin
        make_random_case(t);
      end
      load_operands();
      run_product();
      for (int r = 0; r < MAT_N; r++) begin
        read_c_row(r);
      end
      if (error_count == errors_before) begin
        $display("case %0d passed", t);
        pass_count++;
      end else begin
        $display("case %0d FAILED with %0d errors", t, error_count - errors_before);
        fail_count++;
      end
    end
    $display("cases: %0d passed, %0d failed, %0d errors", pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+sim
hdl/mm_geom_pkg.sv
hdl/mm_ctrl_pkg.sv
hdl/operand_stream_if.sv
hdl/result_row_if.sv
hdl/row_ram.sv
hdl/operand_feeder.sv
hdl/processing_element.sv
hdl/systolic_array.sv
hdl/result_drain.sv
hdl/matmul_top.sv
sim/matmul_tb.sv
